//--- source/drbg_macros.svh
`ifndef DRBG_MACROS_SVH
`define DRBG_MACROS_SVH

// number of mixing rounds in the chain
// also the issue-to-buffer latency in cycles
`define DRBG_ROUNDS 4

// blocks generated per seed before a reseed is requested
// kept small so reseeds are exercised often
`define DRBG_RESEED_INTERVAL 8

// output FIFO entries
// must fit in slot_count_t together with the full value
`define DRBG_BUF_DEPTH 4

`endif

//--- source/drbg_pkg.sv
package drbg_pkg;

  // 256-bit seed from the conditioner
  // upper half feeds the key, lower half the counter
  typedef logic [255:0] seed_t;

  // working key carried alongside each block
  typedef logic [127:0] key_t;

  // counter value, round state or finished output block
  typedef logic [127:0] block_t;

  // blocks issued since the last seed accept
  typedef logic [15:0] blk_count_t;

  // buffer free entries or blocks still in the round chain
  typedef logic [3:0] slot_count_t;

  // controller states
  typedef enum logic [2:0] {
    CTRL_IDLE,
    // waiting for the instantiate seed
    CTRL_SEED_REQ,
    CTRL_RUN,
    // interval used up, let the chain empty
    CTRL_DRAIN,
    CTRL_RESEED_REQ
  } ctrl_state_t;

endpackage

//--- source/drbg_round.sv
`timescale 1ns/10ps

module drbg_round #(
  parameter int ROUND_IDX = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             valid_i,
  input  drbg_pkg::block_t state_i,
  input  drbg_pkg::key_t   key_i,
  output logic             valid_o,
  output drbg_pkg::block_t state_o,
  output drbg_pkg::key_t   key_o
);

  import drbg_pkg::*;

  // round index folded into the lowest key byte
  localparam logic [7:0] ROUND_BYTE = 8'(ROUND_IDX);

  logic [31:0] w0, w1, w2, w3;
  logic [31:0] a0, b1, a2, b3;
  block_t      mixed;
  key_t        round_key;
  block_t      next_state;

  logic        valid_q;
  block_t      state_q;
  key_t        key_q;

  function automatic logic [31:0] rotl32(input logic [31:0] x, input int unsigned n);
    rotl32 = (x << n) | (x >> (32 - n));
  endfunction

  // w0 sits in the low word
  assign {w3, w2, w1, w0} = state_i;

  // first pair
  assign a0 = w0 + w1;
  assign b1 = rotl32(w1, 7) ^ a0;
  // second pair
  assign a2 = w2 + w3;
  assign b3 = rotl32(w3, 13) ^ a2;

  // rotate words one place, old w0 ends up on top
  assign mixed = {a0, b3, a2, b1};

  assign round_key  = key_i ^ key_t'(ROUND_BYTE);
  assign next_state = mixed ^ round_key;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // state and key just follow the valid
  always_ff @(posedge clk) begin
    state_q <= next_state;
    // unmodified key goes on to the next round
    key_q   <= key_i;
  end

  assign valid_o = valid_q;
  assign state_o = state_q;
  assign key_o   = key_q;

endmodule

//--- source/drbg_out_buffer.sv
`timescale 1ns/10ps

module drbg_out_buffer #(
  parameter int DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // from the last round
  input  logic                  mix_valid_i,
  input  drbg_pkg::block_t      mix_block_i,
  input  drbg_pkg::key_t        mix_key_i,
  // credit back to the controller
  output drbg_pkg::slot_count_t free_slots_o,
  // consumer stream
  input  logic                  out_ready_i,
  output logic                  out_valid_o,
  output drbg_pkg::block_t      out_data_o
);

  import drbg_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam slot_count_t FULL_FREE = slot_count_t'(DEPTH);

  // storage, no reset
  block_t           mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  slot_count_t      free_q;

  logic             wr_en;
  logic             rd_en;

  // controller credit keeps writes away from a full FIFO
  assign wr_en = mix_valid_i;
  assign rd_en = out_valid_o && out_ready_i;

  // anything stored means a block is on offer
  assign out_valid_o  = (free_q != FULL_FREE);
  assign out_data_o   = mem[rd_ptr_q];
  assign free_slots_o = free_q;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      // final whitening with the carried key
      mem[wr_ptr_q] <= mix_block_i ^ mix_key_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      free_q   <= FULL_FREE;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      unique case ({wr_en, rd_en})
        2'b10:   free_q <= free_q - slot_count_t'(1);
        2'b01:   free_q <= free_q + slot_count_t'(1);
        default: free_q <= free_q;
      endcase
    end
  end

endmodule

//--- source/drbg_seed_ctrl.sv
`timescale 1ns/10ps

`include "drbg_macros.svh"

module drbg_seed_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  // conditioner side
  input  logic                 seed_valid_i,
  input  drbg_pkg::seed_t      seed_i,
  output logic                 seed_ready_o,
  // buffer credit and chain completion
  input  drbg_pkg::slot_count_t free_slots_i,
  input  logic                 done_i,
  // issue port into the round chain
  output logic                 issue_valid_o,
  output drbg_pkg::block_t     issue_block_o,
  output drbg_pkg::key_t       issue_key_o,
  output drbg_pkg::blk_count_t blocks_since_reseed_o
);

  import drbg_pkg::*;

  localparam blk_count_t INTERVAL = blk_count_t'(`DRBG_RESEED_INTERVAL);

  ctrl_state_t state_q;
  ctrl_state_t state_n;

  // key and counter, payload only
  key_t        key_q;
  block_t      counter_q;

  blk_count_t  blk_count_q;
  // issued but not yet written into the buffer
  slot_count_t in_flight_q;

  logic        seed_fire;
  logic        issue;
  logic        interval_done;

  // seed halves
  key_t        seed_key;
  block_t      seed_ctr;

  assign seed_key = seed_i[255:128];
  assign seed_ctr = seed_i[127:0];

  // ready only while asking for a seed
  assign seed_ready_o = (state_q == CTRL_SEED_REQ) || (state_q == CTRL_RESEED_REQ);
  assign seed_fire    = seed_ready_o && seed_valid_i;

  assign interval_done = (blk_count_q >= INTERVAL);

  // issue only with credit left over after the blocks already in the chain
  assign issue = (state_q == CTRL_RUN) && !interval_done &&
                 (free_slots_i > in_flight_q);

  // counter steps first, the stepped value is the block
  assign issue_valid_o = issue;
  assign issue_block_o = counter_q + block_t'(1);
  assign issue_key_o   = key_q;

  assign blocks_since_reseed_o = blk_count_q;

  // next state
  always_comb begin
    state_n = state_q;
    unique case (state_q)
      CTRL_IDLE: begin
        // one cycle after reset, then ask for the first seed
        state_n = CTRL_SEED_REQ;
      end
      CTRL_SEED_REQ: begin
        if (seed_fire) begin
          state_n = CTRL_RUN;
        end
      end
      CTRL_RUN: begin
        if (interval_done) begin
          state_n = CTRL_DRAIN;
        end
      end
      CTRL_DRAIN: begin
        // chain empty, all blocks of this seed are in the buffer
        if (in_flight_q == '0) begin
          state_n = CTRL_RESEED_REQ;
        end
      end
      CTRL_RESEED_REQ: begin
        if (seed_fire) begin
          state_n = CTRL_RUN;
        end
      end
      default: begin
        state_n = CTRL_IDLE;
      end
    endcase
  end

  // control registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q     <= CTRL_IDLE;
      blk_count_q <= '0;
      in_flight_q <= '0;
    end else begin
      state_q <= state_n;

      // count restarts on every accepted seed
      if (seed_fire) begin
        blk_count_q <= '0;
      end else if (issue) begin
        blk_count_q <= blk_count_q + blk_count_t'(1);
      end

      // done_i is the buffer write of the same edge
      unique case ({issue, done_i})
        2'b10:   in_flight_q <= in_flight_q + slot_count_t'(1);
        2'b01:   in_flight_q <= in_flight_q - slot_count_t'(1);
        default: in_flight_q <= in_flight_q;
      endcase
    end
  end

  // key and counter update
  always_ff @(posedge clk) begin
    if (seed_fire) begin
      // instantiate takes the key as is, reseed folds it into the old one
      if (state_q == CTRL_SEED_REQ) begin
        key_q <= seed_key;
      end else begin
        key_q <= key_q ^ seed_key;
      end
      counter_q <= seed_ctr;
    end else if (issue) begin
      counter_q <= issue_block_o;
    end
  end

endmodule

//--- source/drbg_top.sv
`timescale 1ns/10ps

`include "drbg_macros.svh"

module drbg_top (
  input  logic                 clk,
  input  logic                 rst_n,
  // conditioner
  input  logic                 seed_valid_i,
  input  drbg_pkg::seed_t      seed_i,
  output logic                 seed_ready_o,
  // consumer
  input  logic                 out_ready_i,
  output logic                 out_valid_o,
  output drbg_pkg::block_t     out_data_o,
  // status
  output drbg_pkg::blk_count_t blocks_since_reseed_o
);

  import drbg_pkg::*;

  localparam int ROUNDS = `DRBG_ROUNDS;

  // issue port
  logic        issue_valid;
  block_t      issue_block;
  key_t        issue_key;

  // round chain, stage 0 is the issue port
  logic        chain_valid [ROUNDS+1];
  block_t      chain_state [ROUNDS+1];
  key_t        chain_key   [ROUNDS+1];

  // last round into the buffer
  logic        mix_valid;
  block_t      mix_block;
  key_t        mix_key;

  slot_count_t free_slots;

  drbg_seed_ctrl u_seed_ctrl (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .seed_valid_i          (seed_valid_i),
    .seed_i                (seed_i),
    .seed_ready_o          (seed_ready_o),
    .free_slots_i          (free_slots),
    .done_i                (mix_valid),
    .issue_valid_o         (issue_valid),
    .issue_block_o         (issue_block),
    .issue_key_o           (issue_key),
    .blocks_since_reseed_o (blocks_since_reseed_o)
  );

  assign chain_valid[0] = issue_valid;
  assign chain_state[0] = issue_block;
  assign chain_key[0]   = issue_key;

  // one block moves one round per cycle
  for (genvar g = 0; g < ROUNDS; g++) begin : g_round
    drbg_round #(
      .ROUND_IDX (g + 1)
    ) u_round (
      .clk     (clk),
      .rst_n   (rst_n),
      .valid_i (chain_valid[g]),
      .state_i (chain_state[g]),
      .key_i   (chain_key[g]),
      .valid_o (chain_valid[g+1]),
      .state_o (chain_state[g+1]),
      .key_o   (chain_key[g+1])
    );
  end

  assign mix_valid = chain_valid[ROUNDS];
  assign mix_block = chain_state[ROUNDS];
  assign mix_key   = chain_key[ROUNDS];

  drbg_out_buffer #(
    .DEPTH (`DRBG_BUF_DEPTH)
  ) u_out_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .mix_valid_i  (mix_valid),
    .mix_block_i  (mix_block),
    .mix_key_i    (mix_key),
    .free_slots_o (free_slots),
    .out_ready_i  (out_ready_i),
    .out_valid_o  (out_valid_o),
    .out_data_o   (out_data_o)
  );

endmodule

//--- verif/drbg_properties.sv
`timescale 1ns/10ps

`include "drbg_macros.svh"

module drbg_properties (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  seed_ready_i,
  input  logic                  out_valid_i,
  input  logic                  out_ready_i,
  input  drbg_pkg::block_t      out_data_i,
  input  drbg_pkg::slot_count_t free_slots_i,
  // stage 0 is the issue strobe, 1 to ROUNDS are the round outputs
  input  logic                  chain_valid_i [`DRBG_ROUNDS+1]
);

  import drbg_pkg::*;

  localparam int ROUNDS = `DRBG_ROUNDS;

  logic chain_busy;

  // any round still carrying a block
  always_comb begin
    chain_busy = 1'b0;
    for (int k = 1; k <= ROUNDS; k++) begin
      chain_busy = chain_busy | chain_valid_i[k];
    end
  end

  // oldest block holds until the consumer takes it
  a_out_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_data_i)))
    else $error("output block changed or vanished while stalled");

  // a seed is only asked for once the chain is empty
  a_ready_idle : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(seed_ready_i) |-> !chain_busy)
    else $error("seed ready rose with blocks in the round chain");

  a_free_range : assert property (@(posedge clk) disable iff (!rst_n)
    free_slots_i <= slot_count_t'(`DRBG_BUF_DEPTH))
    else $error("free slot count above buffer depth");

endmodule

//--- verif/drbg_tb.sv
`timescale 1ns/10ps

`include "drbg_macros.svh"

module drbg_tb;

  import drbg_pkg::*;

  localparam int         ROUNDS       = `DRBG_ROUNDS;
  localparam int         SEED_BLOCKS  = `DRBG_RESEED_INTERVAL;
  localparam blk_count_t INTERVAL     = blk_count_t'(`DRBG_RESEED_INTERVAL);
  localparam int         NUM_BLOCKS   = 48;
  // 40 cycles per expected block plus slack for reset and seeding
  localparam int         CYCLE_LIMIT  = NUM_BLOCKS * 40 + 200;
  localparam int         STALL_AT     = 16;
  localparam int         STALL_CYCLES = 60;

  logic       clk;
  logic       rst_n;
  logic       seed_valid_i;
  seed_t      seed_i;
  logic       seed_ready_o;
  logic       out_ready_i;
  logic       out_valid_o;
  block_t     out_data_o;
  blk_count_t blocks_since_reseed_o;

  // model state
  key_t       model_key;
  block_t     model_ctr;
  block_t     expected_q [$];
  logic [31:0] rng = 32'h1f49;
  int         seeds_taken = 0;
  int         received = 0;
  int         cycle_count = 0;
  int         stall_left = 0;
  logic       stall_done = 1'b0;
  logic       zero_after_seed = 1'b0;
  logic       hold_pending = 1'b0;
  block_t     held_data;

  drbg_top u_drbg_top (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .seed_valid_i          (seed_valid_i),
    .seed_i                (seed_i),
    .seed_ready_o          (seed_ready_o),
    .out_ready_i           (out_ready_i),
    .out_valid_o           (out_valid_o),
    .out_data_o            (out_data_o),
    .blocks_since_reseed_o (blocks_since_reseed_o)
  );

  bind drbg_top drbg_properties u_drbg_properties (
    .clk           (clk),
    .rst_n         (rst_n),
    .seed_ready_i  (seed_ready_o),
    .out_valid_i   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .out_data_i    (out_data_o),
    .free_slots_i  (free_slots),
    .chain_valid_i (chain_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rotate_left(input logic [31:0] x, input int n);
    return (x << n) | (x >> (32 - n));
  endfunction

  // one keyed add-rotate-xor round with w0 in the low word
  function automatic block_t apply_round(input block_t s, input key_t k, input int idx);
    logic [31:0] sum01;
    logic [31:0] mix1;
    logic [31:0] sum23;
    logic [31:0] mix3;
    logic [7:0]  idx_byte;
    sum01    = s[31:0] + s[63:32];
    mix1     = rotate_left(s[63:32], 7) ^ sum01;
    sum23    = s[95:64] + s[127:96];
    mix3     = rotate_left(s[127:96], 13) ^ sum23;
    idx_byte = idx[7:0];
    // words after the rotation are w0=mix1 w1=sum23 w2=mix3 w3=sum01
    return {sum01, mix3, sum23, mix1} ^ k ^ {120'd0, idx_byte};
  endfunction

  function automatic block_t expected_block(input block_t ctr, input key_t k);
    block_t s;
    s = ctr;
    for (int r = 1; r <= ROUNDS; r++) begin
      s = apply_round(s, k, r);
    end
    return s ^ k;
  endfunction

  task automatic end_with_failure(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_block(input block_t got, input block_t exp, input string what);
    if (got !== exp) begin
      end_with_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                 $time, what, got, exp));
    end
  endtask

  task automatic check_count(input blk_count_t got, input blk_count_t exp, input string what);
    if (got !== exp) begin
      end_with_failure($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                 $time, what, got, exp));
    end
  endtask

  // instantiate on the first seed and reseed afterwards
  task automatic model_seed(input seed_t s, input logic first);
    if (first) begin
      model_key = s[255:128];
    end else begin
      model_key = model_key ^ s[255:128];
    end
    model_ctr = s[127:0];
    for (int i = 0; i < SEED_BLOCKS; i++) begin
      model_ctr = model_ctr + block_t'(1);
      expected_q.push_back(expected_block(model_ctr, model_key));
    end
  endtask

  // values seen here are the ones present at this rising edge
  task automatic sample_and_check();
    logic seed_fire;
    logic out_fire;
    seed_fire = seed_valid_i && seed_ready_o;
    out_fire  = out_valid_o && out_ready_i;
    if (zero_after_seed) begin
      check_count(blocks_since_reseed_o, '0, "block count after seed accept");
    end
    zero_after_seed = 1'b0;
    // nothing may be offered before the instantiate seed
    if (seeds_taken == 0 && out_valid_o) begin
      end_with_failure("output block offered before the first seed was accepted");
    end
    if (hold_pending && !out_valid_o) begin
      end_with_failure("output valid dropped while a block was waiting");
    end else if (hold_pending) begin
      check_block(out_data_o, held_data, "stalled output block");
    end
    if (out_fire && blocks_since_reseed_o > INTERVAL) begin
      end_with_failure("block count went past the reseed interval");
    end else if (out_fire && expected_q.size() == 0) begin
      end_with_failure("block delivered that no accepted seed accounts for");
    end else if (out_fire) begin
      check_block(out_data_o, expected_q.pop_front(), "output block");
      received++;
    end
    if (seed_fire) begin
      // a reseed only comes after a full interval
      if (seeds_taken > 0) begin
        check_count(blocks_since_reseed_o, INTERVAL, "blocks before reseed");
      end
      model_seed(seed_i, seeds_taken == 0);
      seeds_taken++;
      zero_after_seed = 1'b1;
    end
    hold_pending = out_valid_o && !out_ready_i;
    held_data    = out_data_o;
  endtask

  task automatic drive_next();
    seed_t fresh;
    rng = xorshift32(rng);
    seed_valid_i <= rng[0];
    // one long back-pressure phase once some blocks are through
    if (!stall_done && received >= STALL_AT) begin
      stall_left = STALL_CYCLES;
      stall_done = 1'b1;
    end
    if (stall_left > 0) begin
      out_ready_i <= 1'b0;
      stall_left--;
    end else begin
      out_ready_i <= rng[5];
    end
    for (int i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      fresh[i*32 +: 32] = rng;
    end
    seed_i <= fresh;
  endtask

  initial begin
    rst_n        <= 1'b0;
    seed_valid_i <= 1'b0;
    seed_i       <= '0;
    out_ready_i  <= 1'b0;
    repeat (2) @(posedge clk);
    if (seed_ready_o || out_valid_o) begin
      end_with_failure("handshake outputs high during reset");
    end
    check_count(blocks_since_reseed_o, '0, "block count in reset");
    rst_n <= 1'b1;
    while (received < NUM_BLOCKS) begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
        end_with_failure("timeout: not all expected blocks arrived in time");
      end else begin
        sample_and_check();
        drive_next();
      end
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- sim.f
+incdir+source
source/drbg_pkg.sv
source/drbg_round.sv
source/drbg_out_buffer.sv
source/drbg_seed_ctrl.sv
source/drbg_top.sv
verif/drbg_properties.sv
verif/drbg_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the DRBG testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module drbg_tb -Mdir obj_dir -o drbg_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/drbg_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0
